//--- audio_pkg.sv
// two's complement PCM only; a frame always carries left in the upper half, right in the lower
package audio_pkg;

  // width of one channel sample
  localparam int SAMPLE_W = 16;

  // one signed channel sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // stereo frame as seen on the 32-bit audio bus
  // left sits in bits 31:16, right in bits 15:0
  typedef struct packed {
    sample_t left;
    sample_t right;
  } frame_t;

endpackage : audio_pkg

//--- flanger_pkg.sv
// delay geometry is fixed at build time; MAX_DELAY must stay below DEPTH and fit in DELAY_W bits
package flanger_pkg;

  // delay line capacity in stereo frames
  localparam int DEPTH = 64;

  // each frame is stored as two 16-bit words
  localparam int RAM_WORDS = 128;
  localparam int ADDR_W = 7;

  // sweep range in frames
  localparam int MIN_DELAY = 4;
  localparam int MAX_DELAY = 12;

  // accepted frames between two delay steps
  localparam int SWEEP_DIV = 4;

  // width of the delay value passed to the sequencer
  localparam int DELAY_W = 4;

  // sample sequencer states, one cycle each
  typedef enum logic [2:0] {
    idle     = 3'd0,
    write_hi = 3'd1,
    write_lo = 3'd2,
    read_hi  = 3'd3,
    read_lo  = 3'd4,
    mix      = 3'd5
  } seq_state_t;

endpackage : flanger_pkg

//--- delay_ram_if.sv
// single-port access only; the controller must never raise both enables in the same cycle
interface delay_ram_if
  import flanger_pkg::*;
();

  // driven by the sequencer
  logic              read_enable;
  logic              write_enable;
  logic [ADDR_W-1:0] address;
  logic [15:0]       write_data;

  // driven by the RAM, valid the cycle after a read enable
  logic [15:0]       read_data;

  modport ctrl (
    output read_enable,
    output write_enable,
    output address,
    output write_data,
    input  read_data
  );

  modport mem (
    input  read_enable,
    input  write_enable,
    input  address,
    input  write_data,
    output read_data
  );

endinterface : delay_ram_if

//--- sample_ram.sv
// contents are undefined after power-up; read data holds its value until the next read enable
module sample_ram
  import flanger_pkg::*;
(
  input logic       clk,
  delay_ram_if.mem  ram
);

  // delay line storage, two words per frame
  logic [15:0] mem_array [RAM_WORDS];

  // registered read data
  logic [15:0] rd_word;

  // synchronous write port
  always_ff @(posedge clk) begin
    if (ram.write_enable) begin
      mem_array[ram.address] <= ram.write_data;
    end
  end

  // registered read port
  // word appears the cycle after read_enable and then stays put
  always_ff @(posedge clk) begin
    if (ram.read_enable) begin
      rd_word <= mem_array[ram.address];
    end
  end

  assign ram.read_data = rd_word;

endmodule : sample_ram

//--- sweep_counter.sv
// delay changes only on advance pulses; after reset the sweep starts at MIN_DELAY going upward
module sweep_counter
  import flanger_pkg::*;
(
  input  logic               clk,
  input  logic               n_rst,
  input  logic               advance,
  output logic [DELAY_W-1:0] delay
);

  localparam int PRE_W = (SWEEP_DIV > 1) ? $clog2(SWEEP_DIV) : 1;

  // frames seen since the last delay step
  logic [PRE_W-1:0]   prescale;
  // 1 while the delay is rising
  logic               going_up;
  logic [DELAY_W-1:0] delay_next;
  logic               step;

  assign step = advance && (prescale == PRE_W'(SWEEP_DIV - 1));

  // one step in the current direction
  assign delay_next = going_up ? delay + 1'b1 : delay - 1'b1;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      prescale <= '0;
    end else if (step) begin
      prescale <= '0;
    end else if (advance) begin
      prescale <= prescale + 1'b1;
    end
  end

  // triangle sweep, direction flips on reaching either limit
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      delay    <= DELAY_W'(MIN_DELAY);
      going_up <= 1'b1;
    end else if (step) begin
      delay <= delay_next;
      if (delay_next == DELAY_W'(MAX_DELAY)) begin
        going_up <= 1'b0;
      end else if (delay_next == DELAY_W'(MIN_DELAY)) begin
        going_up <= 1'b1;
      end
    end
  end

endmodule : sweep_counter

//--- flanger.sv
// no back-pressure: shift_en outside idle is dropped; wet output lags shift_en by 5 cycles
module flanger
  import audio_pkg::*;
  import flanger_pkg::*;
(
  input  logic               clk,
  input  logic               n_rst,
  input  logic               flanger_en,
  input  logic               shift_en,
  input  frame_t             input_data,
  input  logic [DELAY_W-1:0] delay,
  output logic               advance,
  delay_ram_if.ctrl          ram,
  output frame_t             output_data
);

  // frame pointer covers DEPTH frames, one address bit less than the word address
  localparam int PTR_BITS = ADDR_W - 1;

  seq_state_t state;
  seq_state_t next_state;

  // write pointer and the pointer to the delayed frame
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;

  // frames written so far, saturating at DEPTH
  logic [ADDR_W-1:0] fill;

  // frame under processing and the last mixed result
  frame_t dry;
  frame_t wet;
  frame_t wet_next;

  // upper word of the delayed frame, caught in read_lo
  sample_t delayed_left;
  frame_t  delayed;
  logic    delayed_valid;

  // average of two samples with sign kept
  function automatic sample_t mix_channel(input sample_t a, input sample_t b);
    logic signed [SAMPLE_W:0] sum;
    sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
    return sample_t'(sum >>> 1);
  endfunction

  // delayed frame sits delay frames behind the write pointer
  // wraps modulo DEPTH through the pointer width
  assign rd_ptr = wr_ptr - PTR_BITS'(delay);

  // unwritten slots read as silence
  assign delayed_valid = (fill >= ADDR_W'(delay));

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // one state per cycle, any drop of flanger_en aborts to idle
  always_comb begin
    next_state = idle;
    case (state)
      idle: begin
        if (flanger_en && shift_en) begin
          next_state = write_hi;
        end
      end
      write_hi: begin
        if (flanger_en) begin
          next_state = write_lo;
        end
      end
      write_lo: begin
        if (flanger_en) begin
          next_state = read_hi;
        end
      end
      read_hi: begin
        if (flanger_en) begin
          next_state = read_lo;
        end
      end
      read_lo: begin
        if (flanger_en) begin
          next_state = mix;
        end
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // RAM access decode
  // enables follow flanger_en so the line freezes at once in bypass
  always_comb begin
    ram.read_enable  = 1'b0;
    ram.write_enable = 1'b0;
    ram.address      = {wr_ptr, 1'b0};
    ram.write_data   = dry.left;
    case (state)
      write_hi: begin
        ram.write_enable = flanger_en;
      end
      write_lo: begin
        ram.write_enable = flanger_en;
        ram.address      = {wr_ptr, 1'b1};
        ram.write_data   = dry.right;
      end
      read_hi: begin
        ram.read_enable = flanger_en;
        ram.address     = {rd_ptr, 1'b0};
      end
      read_lo: begin
        ram.read_enable = flanger_en;
        ram.address     = {rd_ptr, 1'b1};
      end
      default: begin
        ram.read_enable = 1'b0;
      end
    endcase
  end

  // latch the incoming frame when a sequence starts
  always_ff @(posedge clk) begin
    if (state == idle && flanger_en && shift_en) begin
      dry <= input_data;
    end
  end

  // read data in read_lo is the left word from read_hi
  always_ff @(posedge clk) begin
    if (state == read_lo) begin
      delayed_left <= ram.read_data;
    end
  end

  // right word arrives in mix
  assign delayed = delayed_valid ? {delayed_left, ram.read_data} : '0;

  assign wet_next.left  = mix_channel(dry.left, delayed.left);
  assign wet_next.right = mix_channel(dry.right, delayed.right);

  // one pulse per completed frame
  assign advance = (state == mix) && flanger_en;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr <= '0;
      fill   <= '0;
      wet    <= '0;
    end else if (advance) begin
      wr_ptr <= wr_ptr + 1'b1;
      wet    <= wet_next;
      if (fill != ADDR_W'(DEPTH)) begin
        fill <= fill + 1'b1;
      end
    end
  end

  // bypass is combinational
  assign output_data = flanger_en ? wet : input_data;

endmodule : flanger

//--- flanger_top.sv
// one frame per shift_en pulse, at least 8 cycles apart; input is passed through when disabled
module flanger_top
  import audio_pkg::*;
(
  input  logic   clk,
  input  logic   n_rst,
  input  logic   flanger_en,
  input  logic   shift_en,
  input  frame_t input_data,
  output frame_t output_data
);

  // shared RAM bus between sequencer and delay line
  delay_ram_if ram_bus ();

  logic                          advance;
  logic [flanger_pkg::DELAY_W-1:0] delay;

  flanger flanger_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .flanger_en  (flanger_en),
    .shift_en    (shift_en),
    .input_data  (input_data),
    .delay       (delay),
    .advance     (advance),
    .ram         (ram_bus.ctrl),
    .output_data (output_data)
  );

  sample_ram sample_ram_i (
    .clk (clk),
    .ram (ram_bus.mem)
  );

  // delay sweep, stepped by completed frames
  sweep_counter sweep_counter_i (
    .clk     (clk),
    .n_rst   (n_rst),
    .advance (advance),
    .delay   (delay)
  );

endmodule : flanger_top

//--- flanger_assert.sv
// bound into every flanger instance; all checks are held off while n_rst is low
module flanger_assert
  import flanger_pkg::*;
(
  input logic              clk,
  input logic              n_rst,
  input logic              flanger_en,
  input logic              advance,
  input logic              read_enable,
  input logic              write_enable,
  input logic [ADDR_W-1:0] address,
  input seq_state_t        state
);

  // single-port RAM, one access per cycle
  enables_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
    !(read_enable && write_enable))
    else $error("RAM read and write enabled in the same cycle");

  // low word sits right after the high word of the same frame
  word_pair_address: assert property (@(posedge clk) disable iff (!n_rst)
    ((state == write_lo && write_enable) || (state == read_lo && read_enable))
      |-> (address == $past(address) + 1'b1))
    else $error("second RAM word not at the address after the first");

  // advance only closes a complete sequence
  advance_in_mix: assert property (@(posedge clk) disable iff (!n_rst)
    advance |-> (state == mix) && ($past(state) == read_lo))
    else $error("advance pulsed outside the mix state");

  // bypass aborts any running sequence
  idle_when_disabled: assert property (@(posedge clk) disable iff (!n_rst)
    !flanger_en |=> (state == idle))
    else $error("sequencer not idle one cycle after flanger_en went low");

endmodule : flanger_assert

bind flanger flanger_assert flanger_assert_i (
  .clk          (clk),
  .n_rst        (n_rst),
  .flanger_en   (flanger_en),
  .advance      (advance),
  .read_enable  (ram.read_enable),
  .write_enable (ram.write_enable),
  .address      (ram.address),
  .state        (state)
);

//--- tb_flanger.sv
// run from the project root to find flanger_patterns.hex; each check is 8 cycles after shift_en
module tb_flanger
  import audio_pkg::*;
();

  localparam int MAX_ENTRIES = 128;
  localparam int ENTRY_W = 72;

  logic   clk;
  logic   n_rst;
  logic   flanger_en;
  logic   shift_en;
  frame_t input_data;
  frame_t output_data;

  // en byte, input frame, expected output frame
  logic [ENTRY_W-1:0] patterns [MAX_ENTRIES];

  int n_entries;
  int err_count;
  int cycle_count;
  int cycle_limit;

  flanger_top flanger_top_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .flanger_en  (flanger_en),
    .shift_en    (shift_en),
    .input_data  (input_data),
    .output_data (output_data)
  );

  always #50 clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles with %0d errors so far", cycle_count, err_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // entries end at the first slot still holding the 0xff marker
  function automatic int count_entries();
    int n;
    n = 0;
    while (n < MAX_ENTRIES && patterns[n][71:64] != 8'hff) begin
      n++;
    end
    return n;
  endfunction

  // one frame: pulse shift_en, wait for the wet result, compare
  task automatic apply_entry(input logic [ENTRY_W-1:0] entry, input int idx);
    frame_t expected;
    expected = entry[31:0];
    @(posedge clk);
    flanger_en <= entry[64];
    input_data <= entry[63:32];
    shift_en   <= 1'b1;
    @(posedge clk);
    shift_en <= 1'b0;
    repeat (7) @(posedge clk);
    // outputs settle after the edge
    @(negedge clk);
    assert (output_data == expected) else begin
      $display("ERROR: output_data expected %h actual %h at entry %0d",
               expected, output_data, idx);
      err_count++;
    end
  endtask

  initial begin
    clk         = 1'b0;
    n_rst       = 1'b0;
    flanger_en  = 1'b0;
    shift_en    = 1'b0;
    input_data  = '0;
    err_count   = 0;
    cycle_count = 0;
    cycle_limit = 50;
    for (int i = 0; i < MAX_ENTRIES; i++) begin
      patterns[i] = '1;
    end
    $readmemh("flanger_patterns.hex", patterns);
    n_entries   = count_entries();
    cycle_limit = n_entries * 10 + 50;
    if (n_entries == 0) begin
      $display("no pattern entries could be read from flanger_patterns.hex");
      err_count++;
    end

    repeat (4) @(posedge clk);
    n_rst <= 1'b1;

    for (int i = 0; i < n_entries; i++) begin
      apply_entry(patterns[i], i);
    end

    @(posedge clk);
    $display("entries checked: %0d, errors: %0d", n_entries, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_flanger

//--- flanger_patterns.hex
// flanger_en (2 digits) _ input_data left right (8) _ expected output_data left right (8)
// two entries per line, applied in order; first and middle pairs run in bypass
00_12345678_12345678 00_fedc0123_fedc0123
01_7ff08000_3ff8c000 01_7fe08010_3ff0c008
01_7fd08020_3fe8c010 01_7fc08030_3fe0c018
01_7fb08040_3fd8c020 01_7fa08050_7fc88028
01_7f908060_7fb88038 01_7f808070_7fa88048
01_7f708080_7fa08050 01_7f608090_7f908060
01_7f5080a0_7f808070 01_7f4080b0_7f708080
01_7f3080c0_7f688088 01_7f2080d0_7f588098
01_7f1080e0_7f4880a8 01_7f0080f0_7f3880b8
01_7ef08100_7f3080c0 01_7ee08110_7f2080d0
01_7ed08120_7f1080e0 01_7ec08130_7f0080f0
01_7eb08140_7ef880f8 01_7ea08150_7ee88108
01_7e908160_7ed88118 01_7e808170_7ec88128
01_7e708180_7ec08130 01_7e608190_7eb08140
01_7e5081a0_7ea08150 01_7e4081b0_7e908160
01_7e3081c0_7e888168 01_7e2081d0_7e788178
01_7e1081e0_7e688188 01_7e0081f0_7e588198
01_7df08200_7e5081a0 01_7de08210_7e4081b0
01_7dd08220_7e3081c0 01_7dc08230_7e2081d0
01_7db08240_7e0881e8 01_7da08250_7df881f8
01_7d908260_7de88208 01_7d808270_7dd88218
00_a5a55a5a_a5a55a5a 00_00ff8001_00ff8001
01_7d708280_7dc08230 01_7d608290_7db08240
01_7d5082a0_7da08250 01_7d4082b0_7d908260
01_7d3082c0_7d788278 01_7d2082d0_7d688288
01_7d1082e0_7d588298 01_7d0082f0_7d4882a8
01_7cf08300_7d3082c0 01_7ce08310_7d2082d0
01_7cd08320_7d1082e0 01_7cc08330_7d0082f0
01_7cb08340_7ce88308 01_7ca08350_7cd88318
01_7c908360_7cc88328 01_7c808370_7cb88338
01_7c708380_7ca08350 01_7c608390_7c908360
01_7c5083a0_7c808370 01_7c4083b0_7c708380
01_7c3083c0_7c588398 01_7c2083d0_7c4883a8
01_7c1083e0_7c3883b8 01_7c0083f0_7c2883c8
01_7bf08400_7c1083e0 01_7be08410_7c0083f0
01_7bd08420_7bf08400 01_7bc08430_7be08410
01_7bb08440_7bd88418 01_7ba08450_7bc88428
01_7b908460_7bb88438 01_7b808470_7ba88448

//--- project.f
audio_pkg.sv
flanger_pkg.sv
delay_ram_if.sv
sample_ram.sv
sweep_counter.sv
flanger.sv
flanger_top.sv
flanger_assert.sv
tb_flanger.sv

//--- Bender.yml
package:
  name: flanger

sources:
  - audio_pkg.sv
  - flanger_pkg.sv
  - delay_ram_if.sv
  - sample_ram.sv
  - sweep_counter.sv
  - flanger.sv
  - flanger_top.sv
  - target: test
    files:
      - flanger_assert.sv
      - tb_flanger.sv
